// File: rvPkg.sv
package rvPkg;

    localparam int Xlen = 32;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Major opcodes
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    localparam logic [6:0] opLui    = 7'b0110111;
    localparam logic [6:0] opAuipc  = 7'b0010111;
    localparam logic [6:0] opJal    = 7'b1101111;
    localparam logic [6:0] opJalr   = 7'b1100111;
    localparam logic [6:0] opBranch = 7'b1100011;
    localparam logic [6:0] opImm    = 7'b0010011;
    localparam logic [6:0] opReg    = 7'b0110011;
    localparam logic [6:0] opSystem = 7'b1110011;

    // Branch conditions.
    localparam logic [2:0] f3Beq  = 3'b000;
    localparam logic [2:0] f3Bne  = 3'b001;
    localparam logic [2:0] f3Blt  = 3'b100;
    localparam logic [2:0] f3Bge  = 3'b101;
    localparam logic [2:0] f3Bltu = 3'b110;
    localparam logic [2:0] f3Bgeu = 3'b111;

    // ALU selectors for OP and OP-IMM.
    localparam logic [2:0] f3AddSub = 3'b000;
    localparam logic [2:0] f3Sll    = 3'b001;
    localparam logic [2:0] f3Slt    = 3'b010;
    localparam logic [2:0] f3Sltu   = 3'b011;
    localparam logic [2:0] f3Xor    = 3'b100;
    localparam logic [2:0] f3Shr    = 3'b101;
    localparam logic [2:0] f3Or     = 3'b110;
    localparam logic [2:0] f3And    = 3'b111;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Internal ALU operations
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    localparam logic [3:0] aluAdd  = 4'd0;
    localparam logic [3:0] aluSub  = 4'd1;
    localparam logic [3:0] aluSll  = 4'd2;
    localparam logic [3:0] aluSlt  = 4'd3;
    localparam logic [3:0] aluSltu = 4'd4;
    localparam logic [3:0] aluXor  = 4'd5;
    localparam logic [3:0] aluSrl  = 4'd6;
    localparam logic [3:0] aluSra  = 4'd7;
    localparam logic [3:0] aluOr   = 4'd8;
    localparam logic [3:0] aluAnd  = 4'd9;

    // Ecall arguments live in a0 and a7.
    localparam logic [4:0] regA0 = 5'd10;
    localparam logic [4:0] regA7 = 5'd17;

    localparam logic [Xlen-1:0] ledService = 32'h0000_0022;

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } rType;

    typedef struct packed {
        logic [11:0] imm;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } iType;

    typedef struct packed {
        logic       imm12;
        logic [5:0] imm10to5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] imm4to1;
        logic       imm11;
        logic [6:0] opcode;
    } bType;

    typedef struct packed {
        logic [19:0] imm;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } uType;

    typedef struct packed {
        logic       imm20;
        logic [9:0] imm10to1;
        logic       imm11;
        logic [7:0] imm19to12;
        logic [4:0] rd;
        logic [6:0] opcode;
    } jType;

    typedef union packed {
        rType r;
        iType i;
        bType b;
        uType u;
        jType j;
    } instrWord;

endpackage

// File: rvFetch.sv
`timescale 1ns/1ps

module rvFetch import rvPkg::*; #(
    parameter logic [Xlen-1:0] ResetPc = '0
) (
    input  logic            clk,
    input  logic            arstN,
    output logic            wbCyc,
    output logic            wbStb,
    output logic [Xlen-1:0] wbAdr,
    output logic            wbWe,
    input  logic [Xlen-1:0] wbDatI,
    input  logic            wbAck,
    input  logic            accept,
    input  logic            redirect,
    input  logic [Xlen-1:0] redirectPc,
    output logic            instrValid,
    output instrWord        instr,
    output logic [Xlen-1:0] pc
);

    logic            cycQ;
    logic            stbQ;
    logic            discardQ;
    logic            bufValidQ;
    logic [Xlen-1:0] adrQ;
    logic [Xlen-1:0] nextPcQ;
    logic [Xlen-1:0] bufPcQ;
    instrWord        bufInstrQ;
    logic [Xlen-1:0] fetchPc;
    logic            startReq;
    logic            takeWord;

    // A taken branch overrides the sequential address on the same edge.
    assign fetchPc = redirect ? redirectPc : nextPcQ;

    // Only one word can be held, so a new cycle waits for the buffer to drain.
    assign startReq = !cycQ && (!bufValidQ || accept);
    assign takeWord = cycQ && wbAck && !discardQ && !redirect;

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            cycQ      <= 1'b0;
            stbQ      <= 1'b0;
            discardQ  <= 1'b0;
            bufValidQ <= 1'b0;
            adrQ      <= ResetPc;
            nextPcQ   <= ResetPc;
        end else begin
            if (startReq) begin
                cycQ    <= 1'b1;
                stbQ    <= 1'b1;
                adrQ    <= fetchPc;
                nextPcQ <= fetchPc + 32'd4;
            end else if (cycQ && wbAck) begin
                cycQ <= 1'b0;
                stbQ <= 1'b0;
            end else if (redirect) begin
                nextPcQ <= redirectPc;
            end

            // The word in flight is stale once the flow has been redirected.
            if (cycQ && wbAck) begin
                discardQ <= 1'b0;
            end else if (cycQ && redirect) begin
                discardQ <= 1'b1;
            end

            if (takeWord) begin
                bufValidQ <= 1'b1;
            end else if (accept) begin
                bufValidQ <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (takeWord) begin
            bufInstrQ <= wbDatI;
            bufPcQ    <= adrQ;
        end
    end

    assign wbCyc      = cycQ;
    assign wbStb      = stbQ;
    assign wbAdr      = adrQ;
    assign wbWe       = 1'b0;
    assign instrValid = bufValidQ;
    assign instr      = bufInstrQ;
    assign pc         = bufPcQ;

    stbNeedsCyc: assert property (@(posedge clk) disable iff (!arstN) wbStb |-> wbCyc);

    adrHeldUntilAck: assert property (@(posedge clk) disable iff (!arstN)
        (wbStb && !wbAck) |=> (wbStb && $stable(wbAdr)));

endmodule

// File: rvRegFile.sv
`timescale 1ns/1ps

module rvRegFile import rvPkg::*; (
    input  logic            clk,
    input  logic            arstN,
    input  logic [4:0]      rs1,
    input  logic [4:0]      rs2,
    output logic [Xlen-1:0] rd1,
    output logic [Xlen-1:0] rd2,
    input  logic            we,
    input  logic [4:0]      waddr,
    input  logic [Xlen-1:0] wdata
);

    logic [Xlen-1:0] regs [1:31];

    always_ff @(posedge clk) begin
        if (we && (waddr != 5'd0)) begin
            regs[waddr] <= wdata;
        end
    end

    // x0 has no storage behind it.
    assign rd1 = (rs1 == 5'd0) ? '0 : regs[rs1];
    assign rd2 = (rs2 == 5'd0) ? '0 : regs[rs2];

    // Writeback is expected to filter out x0 before it reaches the port.
    noWriteToZero: assert property (@(posedge clk) disable iff (!arstN)
        we |-> (waddr != 5'd0));

endmodule

// File: rvAlu.sv
`timescale 1ns/1ps

module rvAlu import rvPkg::*; (
    input  logic [Xlen-1:0] a,
    input  logic [Xlen-1:0] b,
    input  logic [3:0]      op,
    output logic [Xlen-1:0] result,
    output logic            equal,
    output logic            lessSigned,
    output logic            lessUnsigned
);

    logic [4:0] shamt;

    assign shamt = b[4:0];

    // Compare flags serve both slt and the branch unit.
    assign equal        = (a == b);
    assign lessSigned   = ($signed(a) < $signed(b));
    assign lessUnsigned = (a < b);

    always_comb begin
        case (op)
            aluAdd: begin
                result = a + b;
            end
            aluSub: begin
                result = a - b;
            end
            aluSll: begin
                result = a << shamt;
            end
            aluSlt: begin
                result = {{(Xlen-1){1'b0}}, lessSigned};
            end
            aluSltu: begin
                result = {{(Xlen-1){1'b0}}, lessUnsigned};
            end
            aluXor: begin
                result = a ^ b;
            end
            aluSrl: begin
                result = a >> shamt;
            end
            aluSra: begin
                result = $signed(a) >>> shamt;
            end
            aluOr: begin
                result = a | b;
            end
            aluAnd: begin
                result = a & b;
            end
            default: begin
                result = '0;
            end
        endcase
    end

endmodule

// File: rvExecute.sv
`timescale 1ns/1ps

module rvExecute import rvPkg::*; (
    input  logic            clk,
    input  logic            arstN,
    input  logic            instrValid,
    input  instrWord        instr,
    input  logic [Xlen-1:0] pc,
    output logic            accept,
    output logic            redirect,
    output logic [Xlen-1:0] redirectPc,
    input  logic            halt,
    input  logic            rfWe,
    input  logic [4:0]      rfWaddr,
    input  logic [Xlen-1:0] rfWdata,
    output logic            wbValid,
    output logic [4:0]      wbRd,
    output logic [Xlen-1:0] wbData,
    output logic            wbEcall,
    output logic [Xlen-1:0] wbArg0,
    output logic [Xlen-1:0] wbArg7
);

    logic            isLui, isAuipc, isJal, isJalr, isBranch, isImm, isReg, isEcall;
    logic            writesRd, taken;
    logic [4:0]      rs1Sel, rs2Sel;
    logic [Xlen-1:0] rd1, rd2, opA, opB, imm, aluB, aluResult, result;
    logic [3:0]      aluOp;
    logic            equal, lessSigned, lessUnsigned;

    assign isLui    = (instr.r.opcode == opLui);
    assign isAuipc  = (instr.r.opcode == opAuipc);
    assign isJal    = (instr.r.opcode == opJal);
    assign isJalr   = (instr.r.opcode == opJalr);
    assign isBranch = (instr.r.opcode == opBranch);
    assign isImm    = (instr.r.opcode == opImm);
    assign isReg    = (instr.r.opcode == opReg);
    assign isEcall  = (instr.r.opcode == opSystem) && (instr.i.imm == 12'd0);
    assign writesRd = isLui || isAuipc || isJal || isJalr || isImm || isReg;

    // An ecall reads its service code and argument through the normal ports.
    assign rs1Sel = isEcall ? regA0 : instr.r.rs1;
    assign rs2Sel = isEcall ? regA7 : instr.r.rs2;

    rvRegFile i_rvRegFile (
        .clk(clk), .arstN(arstN), .rs1(rs1Sel), .rs2(rs2Sel), .rd1(rd1), .rd2(rd2),
        .we(rfWe), .waddr(rfWaddr), .wdata(rfWdata)
    );

    // The word in writeback is not in the file until the next edge.
    assign opA = (rfWe && (rfWaddr == rs1Sel)) ? rfWdata : rd1;
    assign opB = (rfWe && (rfWaddr == rs2Sel)) ? rfWdata : rd2;

    always_comb begin
        case (instr.r.opcode)
            opBranch: imm = {{19{instr.b.imm12}}, instr.b.imm12, instr.b.imm11,
                             instr.b.imm10to5, instr.b.imm4to1, 1'b0};
            opJal:    imm = {{11{instr.j.imm20}}, instr.j.imm20, instr.j.imm19to12,
                             instr.j.imm11, instr.j.imm10to1, 1'b0};
            opLui,
            opAuipc:  imm = {instr.u.imm, 12'd0};
            default:  imm = {{20{instr.i.imm[11]}}, instr.i.imm};
        endcase
    end

    always_comb begin
        case (instr.r.funct3)
            f3AddSub: aluOp = (isReg && instr.r.funct7[5]) ? aluSub : aluAdd;
            f3Sll:    aluOp = aluSll;
            f3Slt:    aluOp = aluSlt;
            f3Sltu:   aluOp = aluSltu;
            f3Xor:    aluOp = aluXor;
            f3Shr:    aluOp = instr.r.funct7[5] ? aluSra : aluSrl;
            f3Or:     aluOp = aluOr;
            default:  aluOp = aluAnd;
        endcase
        if (isJalr) begin
            aluOp = aluAdd;
        end
    end

    assign aluB = (isReg || isBranch) ? opB : imm;

    rvAlu i_rvAlu (
        .a(opA), .b(aluB), .op(aluOp), .result(aluResult),
        .equal(equal), .lessSigned(lessSigned), .lessUnsigned(lessUnsigned)
    );

    always_comb begin
        case (instr.b.funct3)
            f3Beq:   taken = equal;
            f3Bne:   taken = !equal;
            f3Blt:   taken = lessSigned;
            f3Bge:   taken = !lessSigned;
            f3Bltu:  taken = lessUnsigned;
            f3Bgeu:  taken = !lessUnsigned;
            default: taken = 1'b0;
        endcase
    end

    always_comb begin
        if (isLui) begin
            result = imm;
        end else if (isAuipc) begin
            result = pc + imm;
        end else if (isJal || isJalr) begin
            result = pc + 32'd4;
        end else begin
            result = aluResult;
        end
    end

    assign accept     = instrValid && !halt;
    assign redirect   = accept && (isJal || isJalr || (isBranch && taken));
    assign redirectPc = isJalr ? {aluResult[Xlen-1:1], 1'b0} : (pc + imm);

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            wbValid <= 1'b0;
        end else begin
            wbValid <= accept;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            wbRd    <= writesRd ? instr.r.rd : 5'd0;
            wbData  <= result;
            wbEcall <= isEcall;
            wbArg0  <= opA;
            wbArg7  <= opB;
        end
    end

endmodule

// File: rvWriteback.sv
`timescale 1ns/1ps

module rvWriteback import rvPkg::*; (
    input  logic            clk,
    input  logic            arstN,
    input  logic            go,
    input  logic            wbValid,
    input  logic [4:0]      wbRd,
    input  logic [Xlen-1:0] wbData,
    input  logic            wbEcall,
    input  logic [Xlen-1:0] wbArg0,
    input  logic [Xlen-1:0] wbArg7,
    output logic            rfWe,
    output logic [4:0]      rfWaddr,
    output logic [Xlen-1:0] rfWdata,
    output logic            halt,
    output logic [Xlen-1:0] ledData
);

    logic ledHit;
    logic haltHit;
    logic haltQ;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Register write port
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    assign rfWe    = wbValid && (wbRd != 5'd0);
    assign rfWaddr = wbRd;
    assign rfWdata = wbData;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Environment call
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    assign ledHit  = wbValid && wbEcall && (wbArg7 == ledService);
    assign haltHit = wbValid && wbEcall && (wbArg7 != ledService);

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            ledData <= '0;
            haltQ   <= 1'b0;
        end else begin
            if (ledHit) begin
                ledData <= wbArg0;
            end
            // A fresh halting ecall wins over a go in the same cycle.
            if (haltHit) begin
                haltQ <= 1'b1;
            end else if (go) begin
                haltQ <= 1'b0;
            end
        end
    end

    // Execute must stall already in the cycle the ecall sits here.
    assign halt = haltQ || haltHit;

endmodule

// File: rvCore.sv
`timescale 1ns/1ps

module rvCore import rvPkg::*; #(
    parameter logic [Xlen-1:0] ResetPc = '0
) (
    input  logic            clk,
    input  logic            arstN,
    input  logic            go,
    output logic            wbCyc,
    output logic            wbStb,
    output logic [Xlen-1:0] wbAdr,
    output logic            wbWe,
    input  logic [Xlen-1:0] wbDatI,
    input  logic            wbAck,
    output logic [Xlen-1:0] ledData
);

    logic            instrValid;
    instrWord        instr;
    logic [Xlen-1:0] pc;
    logic            accept;
    logic            redirect;
    logic [Xlen-1:0] redirectPc;

    logic            wbValid;
    logic [4:0]      wbRd;
    logic [Xlen-1:0] wbData;
    logic            wbEcall;
    logic [Xlen-1:0] wbArg0;
    logic [Xlen-1:0] wbArg7;

    logic            rfWe;
    logic [4:0]      rfWaddr;
    logic [Xlen-1:0] rfWdata;
    logic            halt;

    rvFetch #(.ResetPc(ResetPc)) i_rvFetch (
        .clk(clk), .arstN(arstN), .wbCyc(wbCyc), .wbStb(wbStb), .wbAdr(wbAdr),
        .wbWe(wbWe), .wbDatI(wbDatI), .wbAck(wbAck), .accept(accept),
        .redirect(redirect), .redirectPc(redirectPc), .instrValid(instrValid),
        .instr(instr), .pc(pc)
    );

    rvExecute i_rvExecute (
        .clk(clk), .arstN(arstN), .instrValid(instrValid), .instr(instr), .pc(pc),
        .accept(accept), .redirect(redirect), .redirectPc(redirectPc), .halt(halt),
        .rfWe(rfWe), .rfWaddr(rfWaddr), .rfWdata(rfWdata), .wbValid(wbValid),
        .wbRd(wbRd), .wbData(wbData), .wbEcall(wbEcall), .wbArg0(wbArg0), .wbArg7(wbArg7)
    );

    rvWriteback i_rvWriteback (
        .clk(clk), .arstN(arstN), .go(go), .wbValid(wbValid), .wbRd(wbRd),
        .wbData(wbData), .wbEcall(wbEcall), .wbArg0(wbArg0), .wbArg7(wbArg7),
        .rfWe(rfWe), .rfWaddr(rfWaddr), .rfWdata(rfWdata), .halt(halt), .ledData(ledData)
    );

endmodule

// File: tbRvProgram.svh
`ifndef TB_RV_PROGRAM_SVH
`define TB_RV_PROGRAM_SVH

localparam int ProgLen  = 74;
localparam int ExpCount = 22;

localparam logic [31:0] Poison = 32'h0000_05AD;
localparam logic [31:0] Ecall  = 32'h0000_0073;
localparam logic [6:0]  OpImm  = 7'b0010011;

// ABI register numbers used by the program.
localparam int ra = 1;
localparam int t0 = 5;
localparam int t1 = 6;
localparam int t2 = 7;
localparam int a0 = 10;
localparam int a7 = 17;

logic [31:0] prog [0:ProgLen-1];
logic [31:0] expLed [0:ExpCount-1];

function automatic logic [31:0] encI(input int imm, input int rs1, input logic [2:0] f3,
                                     input int rd, input logic [6:0] op);
    logic [31:0] v;
    v = imm;
    return {v[11:0], 5'(rs1), f3, 5'(rd), op};
endfunction

function automatic logic [31:0] encR(input logic [6:0] f7, input int rs2, input int rs1,
                                     input logic [2:0] f3, input int rd);
    return {f7, 5'(rs2), 5'(rs1), f3, 5'(rd), 7'b0110011};
endfunction

function automatic logic [31:0] encB(input int imm, input int rs2, input int rs1,
                                     input logic [2:0] f3);
    logic [31:0] v;
    v = imm;
    return {v[12], v[10:5], 5'(rs2), 5'(rs1), f3, v[4:1], v[11], 7'b1100011};
endfunction

function automatic logic [31:0] encU(input logic [19:0] imm, input int rd,
                                     input logic [6:0] op);
    return {imm, 5'(rd), op};
endfunction

function automatic logic [31:0] encJ(input int imm, input int rd);
    logic [31:0] v;
    v = imm;
    return {v[20], v[10:1], v[11], v[19:12], 5'(rd), 7'b1101111};
endfunction

task automatic loadProgram();
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // ALU and immediates
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    prog[0]  = encI(34, 0, 3'd0, a7, OpImm);
    prog[1]  = encI(100, 0, 3'd0, t0, OpImm);
    prog[2]  = encI(-7, 0, 3'd0, t1, OpImm);
    prog[3]  = encR(7'h00, t1, t0, 3'd0, a0);
    prog[4]  = Ecall;
    prog[5]  = encR(7'h20, t1, t0, 3'd0, a0);
    prog[6]  = Ecall;
    prog[7]  = encI(4, t0, 3'd1, t2, OpImm);
    prog[8]  = encI(1, t2, 3'd0, a0, OpImm);
    prog[9]  = Ecall;
    prog[10] = encI(32'h401, t1, 3'd5, a0, OpImm);
    prog[11] = Ecall;
    prog[12] = encI(28, t1, 3'd5, a0, OpImm);
    prog[13] = Ecall;
    prog[14] = encI(60, t0, 3'd4, a0, OpImm);
    prog[15] = Ecall;
    prog[16] = encR(7'h00, t1, t0, 3'd6, a0);
    prog[17] = Ecall;
    prog[18] = encI(127, t1, 3'd7, a0, OpImm);
    prog[19] = Ecall;
    prog[20] = encR(7'h00, t0, t1, 3'd2, a0);
    prog[21] = Ecall;
    prog[22] = encR(7'h00, t0, t1, 3'd3, a0);
    prog[23] = Ecall;
    prog[24] = encU(20'h12345, a0, 7'b0110111);
    prog[25] = Ecall;
    prog[26] = encU(20'h00001, a0, 7'b0010111);
    prog[27] = Ecall;
    // Dependent chain.
    prog[28] = encI(1, t0, 3'd0, t2, OpImm);
    prog[29] = encR(7'h00, t2, t2, 3'd0, t2);
    prog[30] = encR(7'h00, t0, t2, 3'd0, a0);
    prog[31] = Ecall;
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Branches and jumps
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    prog[32] = encB(12, t0, t0, 3'd0);
    prog[33] = encI(Poison, 0, 3'd0, a0, OpImm);
    prog[34] = Ecall;
    prog[35] = encI(1, 0, 3'd0, a0, OpImm);
    prog[36] = Ecall;
    prog[37] = encB(8, t0, t0, 3'd1);
    prog[38] = encI(2, 0, 3'd0, a0, OpImm);
    prog[39] = Ecall;
    prog[40] = encB(12, t0, t1, 3'd4);
    prog[41] = encI(Poison, 0, 3'd0, a0, OpImm);
    prog[42] = Ecall;
    prog[43] = encI(3, 0, 3'd0, a0, OpImm);
    prog[44] = Ecall;
    prog[45] = encB(8, t0, t1, 3'd5);
    prog[46] = encI(4, 0, 3'd0, a0, OpImm);
    prog[47] = Ecall;
    prog[48] = encB(12, t1, t0, 3'd6);
    prog[49] = encI(Poison, 0, 3'd0, a0, OpImm);
    prog[50] = Ecall;
    prog[51] = encI(5, 0, 3'd0, a0, OpImm);
    prog[52] = Ecall;
    prog[53] = encB(8, t1, t0, 3'd7);
    prog[54] = encI(6, 0, 3'd0, a0, OpImm);
    prog[55] = Ecall;
    prog[56] = encJ(12, ra);
    prog[57] = encI(Poison, 0, 3'd0, a0, OpImm);
    prog[58] = Ecall;
    prog[59] = encI(0, ra, 3'd0, a0, OpImm);
    prog[60] = Ecall;
    prog[61] = encU(20'h00000, t2, 7'b0010111);
    prog[62] = encI(21, t2, 3'd0, 0, 7'b1100111);
    prog[63] = encI(Poison, 0, 3'd0, a0, OpImm);
    prog[64] = Ecall;
    prog[65] = encI(Poison, 0, 3'd0, a0, OpImm);
    prog[66] = encI(7, 0, 3'd0, a0, OpImm);
    prog[67] = Ecall;
    // Halting ecall, then one more LED value once go arrives.
    prog[68] = encI(0, 0, 3'd0, a7, OpImm);
    prog[69] = Ecall;
    prog[70] = encI(34, 0, 3'd0, a7, OpImm);
    prog[71] = encI(8, 0, 3'd0, a0, OpImm);
    prog[72] = Ecall;
    prog[73] = encJ(0, 0);

    expLed[0]  = 32'd93;
    expLed[1]  = 32'd107;
    expLed[2]  = 32'd1601;
    expLed[3]  = 32'hFFFF_FFFC;
    expLed[4]  = 32'h0000_000F;
    expLed[5]  = 32'd88;
    expLed[6]  = 32'hFFFF_FFFD;
    expLed[7]  = 32'd121;
    expLed[8]  = 32'd1;
    expLed[9]  = 32'd0;
    expLed[10] = 32'h1234_5000;
    expLed[11] = 32'h0000_1168;
    expLed[12] = 32'd302;
    expLed[13] = 32'd1;
    expLed[14] = 32'd2;
    expLed[15] = 32'd3;
    expLed[16] = 32'd4;
    expLed[17] = 32'd5;
    expLed[18] = 32'd6;
    expLed[19] = 32'h0000_01E4;
    expLed[20] = 32'd7;
    expLed[21] = 32'd8;
endtask

`endif

// File: tbRvCore.sv
`timescale 1ns/1ps

module tbRvCore;

    localparam logic [31:0] ResetPc = 32'h0000_0100;
    localparam int MaxFetch = 5;
    localparam int HaltWait = 30;

    logic        clk;
    logic        arstN;
    logic        go;
    logic        wbCyc;
    logic        wbStb;
    logic [31:0] wbAdr;
    logic        wbWe;
    logic [31:0] wbDatI;
    logic        wbAck;
    logic [31:0] ledData;

    `include "tbRvProgram.svh"

    localparam int CycleLimit = 4 * ProgLen * MaxFetch + HaltWait;

    int unsigned lcgState = 44;
    int          errCount = 0;
    int          otherErr = 0;
    int          cycles = 0;
    int          ackDelay = 0;
    logic        busy = 1'b0;
    logic        firstAckSeen = 1'b0;
    logic [31:0] prevLed = '0;
    logic        ledChanged = 1'b0;
    int          ledIdx = 0;
    int          curIdx = 0;
    logic        inHaltWait = 1'b0;
    logic        goSent = 1'b0;
    int          haltCycles = 0;
    int          haltAcks = 0;
    logic        done = 1'b0;
    logic        timedOut = 1'b0;

    rvCore #(.ResetPc(ResetPc)) i_rvCore (
        .clk(clk), .arstN(arstN), .go(go), .wbCyc(wbCyc), .wbStb(wbStb), .wbAdr(wbAdr),
        .wbWe(wbWe), .wbDatI(wbDatI), .wbAck(wbAck), .ledData(ledData)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    function automatic int nextRand();
        lcgState = lcgState * 32'd1103515245 + 32'd12345;
        return int'(lcgState[30:16]);
    endfunction

    function automatic logic [31:0] readWord(input logic [31:0] adr);
        int idx;
        idx = (adr - ResetPc) >> 2;
        if (adr < ResetPc || idx >= ProgLen) begin
            otherErr++;
            $display("Fetch outside the program at address %h", adr);
            return 32'h0000_0013;
        end
        return prog[idx];
    endfunction

    task automatic reportFailure(input string msg);
        errCount++;
        $display("FAIL %0t: %s", $time, msg);
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Memory model and monitors
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always @(negedge clk) begin
        if (!arstN) begin
            wbAck <= 1'b0;
            busy = 1'b0;
        end else begin
            cycles <= cycles + 1;
            if (cycles + 1 >= CycleLimit) begin
                timedOut <= 1'b1;
            end

            if (wbAck) begin
                wbAck        <= 1'b0;
                busy = 1'b0;
                firstAckSeen <= 1'b1;
            end else if (wbCyc && wbStb) begin
                if (!busy) begin
                    busy = 1'b1;
                    ackDelay = nextRand() % 4;
                end
                if (ackDelay == 0) begin
                    wbAck  <= 1'b1;
                    wbDatI <= readWord(wbAdr);
                    if (inHaltWait) begin
                        haltAcks <= haltAcks + 1;
                    end
                end else begin
                    ackDelay = ackDelay - 1;
                end
            end

            if (ledData != prevLed) begin
                ledChanged <= 1'b1;
                curIdx     <= ledIdx;
                ledIdx     <= ledIdx + 1;
                prevLed    <= ledData;
                if (ledIdx + 1 == ExpCount) begin
                    done <= 1'b1;
                end
            end else begin
                ledChanged <= 1'b0;
            end

            // Hold the core in halt for a while, then release it with a go pulse.
            if (!inHaltWait && !goSent && i_rvCore.halt) begin
                inHaltWait <= 1'b1;
                haltCycles <= 0;
                haltAcks   <= 0;
            end else if (inHaltWait) begin
                haltCycles <= haltCycles + 1;
                if (haltCycles + 1 == HaltWait) begin
                    go         <= 1'b1;
                    goSent     <= 1'b1;
                    inHaltWait <= 1'b0;
                end
            end else begin
                go <= 1'b0;
            end
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Checks
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    resetQuiet: assert property (@(posedge clk) !arstN |-> (!wbCyc && !wbStb && ledData == 0))
        else reportFailure("bus or LED active in reset");

    firstAddress: assert property (@(posedge clk) disable iff (!arstN)
        (wbCyc && !firstAckSeen) |-> (wbAdr == ResetPc))
        else reportFailure($sformatf("first fetch at %h", wbAdr));

    stbWithCyc: assert property (@(posedge clk) disable iff (!arstN) wbStb |-> wbCyc)
        else reportFailure("stb without cyc");

    readOnly: assert property (@(posedge clk) disable iff (!arstN) !wbWe)
        else reportFailure("write enable raised");

    aligned: assert property (@(posedge clk) disable iff (!arstN) wbCyc |-> (wbAdr[1:0] == 0))
        else reportFailure($sformatf("unaligned address %h", wbAdr));

    adrStable: assert property (@(posedge clk) disable iff (!arstN)
        (wbStb && !wbAck) |=> (wbStb && $stable(wbAdr)))
        else reportFailure("address moved before ack");

    ledSequence: assert property (@(posedge clk) disable iff (!arstN)
        ledChanged |-> (curIdx < ExpCount && ledData == expLed[curIdx]))
        else reportFailure($sformatf("LED value %h at position %0d", ledData, curIdx));

    noPoison: assert property (@(posedge clk) disable iff (!arstN) ledData != Poison)
        else reportFailure("skipped instruction reached LED");

    haltHoldsLed: assert property (@(posedge clk) disable iff (!arstN)
        inHaltWait |-> $stable(ledData))
        else reportFailure("LED changed while halted");

    haltHoldsBus: assert property (@(posedge clk) disable iff (!arstN)
        inHaltWait |-> (haltAcks <= 1))
        else reportFailure("fetch went on while halted");

    // The last LED value sits behind the halting ecall.
    lastNeedsGo: assert property (@(posedge clk) disable iff (!arstN)
        (ledChanged && curIdx == ExpCount - 1) |-> goSent)
        else reportFailure("last LED value appeared without a go pulse");

    initial begin
        arstN  = 1'b0;
        go     = 1'b0;
        wbAck  = 1'b0;
        wbDatI = '0;
        loadProgram();
        repeat (2) @(negedge clk);
        arstN = 1'b1;
        wait (done || timedOut);
        if (!done) begin
            otherErr++;
            $display("Timeout after %0d cycles with %0d of %0d LED values seen",
                     cycles, ledIdx, ExpCount);
        end
        repeat (3) @(negedge clk);
        $display("Summary: %0d assertion failures, %0d other failures, %0d LED values",
                 errCount, otherErr, ledIdx);
        if (errCount + otherErr == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

// File: rvCore.f
+incdir+.
rvPkg.sv
rvFetch.sv
rvRegFile.sv
rvAlu.sv
rvExecute.sv
rvWriteback.sv
rvCore.sv
tbRvCore.sv
